// ==== split_write_golden.txt ====
# test kind split address value, all hex
# kind 0 writes D with split and data, kind 1 reads A and kind 2 reads B at a bank address
1 1 0 000 0000
1 2 0 000 0000
1 1 0 1FF 0000
1 2 0 1FF 0000
2 0 0 015 1234
2 1 0 015 1234
2 2 0 015 0000
3 0 0 215 ABCD
3 2 0 015 ABCD
3 1 0 015 1234
4 0 1 0A7 5A5A
4 0 1 3FF C3C3
4 1 0 005 5A5A
4 2 0 007 5A5A
4 1 0 01F C3C3
4 2 0 01F C3C3
5 0 0 040 1111
5 0 1 0C3 2222
5 0 0 240 3333
5 0 0 006 4444
5 0 1 1E9 5555
5 0 0 203 6666
5 0 0 1FF 7777
5 0 1 0E9 8888
5 1 0 040 1111
5 1 0 006 4444
5 2 0 003 6666
5 2 0 040 3333
5 1 0 00F 5555
5 2 0 009 8888
5 1 0 1FF 7777
5 1 0 007 8888

// ==== files.f ====
write_path_pkg.sv
address_splitter.sv
write_address_decoder.sv
banked_data_memory.sv
split_write_path.sv
split_write_path_assertions.sv
tb_split_write_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_split_write_path \
    --Mdir "$build_dir" \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" | tee "$log_file"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -q "^TEST OK$" "$log_file"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== tb_split_write_path.sv ====
`timescale 1ns/1ns

module tb_split_write_path;

    import write_path_pkg::*;

    localparam int clock_period = 10;
    localparam string golden_path = "split_write_golden.txt";

    // --------------------
    // DUT signals

    logic clock;
    logic reset;
    write_command_t write_command;
    logic [bank_addr_width-1:0] read_address_a;
    logic [bank_addr_width-1:0] read_address_b;
    logic [data_width-1:0] read_data_a;
    logic [data_width-1:0] read_data_b;

    // Golden entries with one slot per data line of the file
    int test_q[$];
    int kind_q[$];
    int split_q[$];
    int addr_q[$];
    int value_q[$];

    int file_line_count;
    bit file_loaded;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int current_test;
    bit writes_pending;

    split_write_path split_write_path_inst (
        .clock(clock),
        .reset(reset),
        .write_command(write_command),
        .read_address_a(read_address_a),
        .read_address_b(read_address_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b)
    );

    // Decoder checks ride along on every instance of the decoder
    bind write_address_decoder split_write_path_assertions decoder_assertions_inst (
        .clock(clock),
        .reset(reset),
        .split_command(split_command),
        .bank_write_a(bank_write_a),
        .bank_write_b(bank_write_b)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    // --------------------
    // Helpers

    // Columns are test, kind, split, address and value in hex
    // Lines that start with # are notes and carry no entry
    task automatic load_golden();
        int fd;
        int count;
        int t;
        int k;
        int s;
        int a;
        int v;
        string line;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", golden_path);
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    file_line_count++;
                    if (line.len() > 0 && line.getc(0) != "#") begin
                        count = $sscanf(line, "%h %h %h %h %h", t, k, s, a, v);
                        if (count == 5) begin
                            test_q.push_back(t);
                            kind_q.push_back(k);
                            split_q.push_back(s);
                            addr_q.push_back(a);
                            value_q.push_back(v);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One command per call, so calls in a row give back to back cycles
    task automatic apply_write(input int split, input int addr, input int value);
        @(posedge clock);
        write_command.valid <= 1'b1;
        write_command.split <= split[0];
        write_command.address.full <= addr[addr_width-1:0];
        write_command.data <= value[data_width-1:0];
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            write_command.valid <= 1'b0;
        end
    endtask

    // Address goes out on one edge, the bank samples it on the next, and the
    // data is looked at on the falling edge after that
    task automatic check_read(input int kind, input int addr, input int expected);
        @(posedge clock);
        write_command.valid <= 1'b0;
        if (kind == 1) begin
            read_address_a <= addr[bank_addr_width-1:0];
        end else begin
            read_address_b <= addr[bank_addr_width-1:0];
        end
        @(posedge clock);
        @(negedge clock);
        if (kind == 1) begin
            if (read_data_a !== expected[data_width-1:0]) begin
                $display("FAIL read_data_a at %h expected %h actual %h",
                         addr[bank_addr_width-1:0], expected[data_width-1:0], read_data_a);
                test_errors++;
            end
        end else begin
            if (read_data_b !== expected[data_width-1:0]) begin
                $display("FAIL read_data_b at %h expected %h actual %h",
                         addr[bank_addr_width-1:0], expected[data_width-1:0], read_data_b);
                test_errors++;
            end
        end
    endtask

    task automatic close_test(input int test_id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0h passed", test_id);
        end else begin
            tests_failed++;
            $display("test %0h failed with %0d errors", test_id, test_errors);
        end
        test_errors = 0;
    endtask

    // --------------------
    // Main sequence

    initial begin
        reset = 1'b1;
        write_command = '0;
        read_address_a = '0;
        read_address_b = '0;
        load_golden();
        file_loaded = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        if (test_q.size() == 0) begin
            $display("The golden file holds no entries");
            tests_failed++;
        end else begin
            current_test = test_q[0];
            for (int i = 0; i < test_q.size(); i++) begin
                if (test_q[i] != current_test) begin
                    close_test(current_test);
                    current_test = test_q[i];
                end
                if (kind_q[i] == 0) begin
                    apply_write(split_q[i], addr_q[i], value_q[i]);
                    writes_pending = 1'b1;
                end else if (kind_q[i] == 1 || kind_q[i] == 2) begin
                    // Let the last write drain through both stages first
                    if (writes_pending) begin
                        idle_cycles(3);
                        writes_pending = 1'b0;
                    end
                    check_read(kind_q[i], addr_q[i], value_q[i]);
                end else begin
                    $display("Golden entry %0d has unknown kind %0h", i, kind_q[i]);
                    test_errors++;
                end
            end
            close_test(current_test);
        end
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // --------------------
    // Watchdog

    // Budget is four clock periods per golden file line plus 20 lines of slack
    initial begin
        wait (file_loaded);
        #((file_line_count + 20) * 4 * clock_period);
        $display("Run timed out before all golden entries were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== split_write_path_assertions.sv ====
`timescale 1ns/1ns

module split_write_path_assertions (
    input logic clock,
    input logic reset,
    input write_path_pkg::split_command_t split_command,
    input write_path_pkg::bank_write_t bank_write_a,
    input write_path_pkg::bank_write_t bank_write_b
);

    // --------------------
    // Reset

    // A cycle in reset leaves both bank enables low on the next edge
    reset_clears_enables: assert property (
        @(posedge clock) reset |=> !bank_write_a.enable && !bank_write_b.enable
    ) else $error("Bank enable high in the cycle after reset");

    // --------------------
    // Bank selection

    // Unsplit commands carry the same address in DA and DB
    // A split command always differs in the range bit, so DA never equals DB
    unsplit_hits_one_bank: assert property (
        @(posedge clock) disable iff (reset)
        split_command.valid && (split_command.da == split_command.db)
        |=> $onehot({bank_write_a.enable, bank_write_b.enable})
    ) else $error("Unsplit command did not enable exactly one bank");

    // Both banks store the word that the split command carried
    split_hits_both_banks: assert property (
        @(posedge clock) disable iff (reset)
        split_command.valid && (split_command.da != split_command.db)
        |=> bank_write_a.enable && bank_write_b.enable
            && (bank_write_a.data == $past(split_command.data))
            && (bank_write_b.data == $past(split_command.data))
    ) else $error("Split command did not write both banks with equal data");

endmodule

// ==== split_write_path.sv ====
`timescale 1ns/1ns

module split_write_path (
    input  logic clock,
    input  logic reset,
    input  write_path_pkg::write_command_t write_command,
    input  logic [write_path_pkg::bank_addr_width-1:0] read_address_a,
    input  logic [write_path_pkg::bank_addr_width-1:0] read_address_b,
    output logic [write_path_pkg::data_width-1:0] read_data_a,
    output logic [write_path_pkg::data_width-1:0] read_data_b
);

    import write_path_pkg::*;

    // --------------------
    // Stage to stage wiring

    // Splitter output, one cycle after the command
    split_command_t split_command;

    // Decoder outputs, one cycle after the split command
    bank_write_t bank_write_a;
    bank_write_t bank_write_b;

    // --------------------
    // Pipeline

    // Stage 1 forms DA and DB from D
    address_splitter address_splitter_inst (
        .clock(clock),
        .reset(reset),
        .write_command(write_command),
        .split_command(split_command)
    );

    // Stage 2 turns DA and DB into per bank writes
    write_address_decoder write_address_decoder_inst (
        .clock(clock),
        .reset(reset),
        .split_command(split_command),
        .bank_write_a(bank_write_a),
        .bank_write_b(bank_write_b)
    );

    // Stage 3 stores the words, memory A
    banked_data_memory bank_a (
        .clock(clock),
        .bank_write(bank_write_a),
        .read_address(read_address_a),
        .read_data(read_data_a)
    );

    // Memory B, same bank with its own read port
    banked_data_memory bank_b (
        .clock(clock),
        .bank_write(bank_write_b),
        .read_address(read_address_b),
        .read_data(read_data_b)
    );

endmodule

// ==== banked_data_memory.sv ====
`timescale 1ns/1ns

module banked_data_memory (
    input  logic clock,
    input  write_path_pkg::bank_write_t bank_write,
    input  logic [write_path_pkg::bank_addr_width-1:0] read_address,
    output logic [write_path_pkg::data_width-1:0] read_data
);

    import write_path_pkg::*;

    // --------------------
    // Storage

    // One word per bank local address
    logic [data_width-1:0] memory [0:(2**bank_addr_width)-1];

    // Contents start cleared so that unwritten words read back as zero
    // Reset leaves the array alone
    initial begin
        for (int i = 0; i < 2**bank_addr_width; i++) begin
            memory[i] = '0;
        end
    end

    // --------------------
    // Write and read ports

    // Write takes effect at the edge where the enable is high
    always_ff @(posedge clock) begin
        if (bank_write.enable) begin
            memory[bank_write.address] <= bank_write.data;
        end
    end

    // A read and a write to the same word in one cycle return the old
    // contents, and the new word shows up on the next read
    always_ff @(posedge clock) begin
        read_data <= memory[read_address];
    end

endmodule

// ==== write_address_decoder.sv ====
`timescale 1ns/1ns

module write_address_decoder (
    input  logic clock,
    input  logic reset,
    input  write_path_pkg::split_command_t split_command,
    output write_path_pkg::bank_write_t bank_write_a,
    output write_path_pkg::bank_write_t bank_write_b
);

    import write_path_pkg::*;

    // --------------------
    // Range decode

    // With two banks of 512 words the top address bit alone selects the
    // bank, so each range check compares that bit against the bank base
    logic hit_a;
    logic hit_b;

    // DA is only ever written into A and DB only into B
    // An unsplit command has DA equal to DB, so exactly one of these is set
    always_comb begin
        hit_a = split_command.da[addr_width-1] == a_base_addr[addr_width-1];
        hit_b = split_command.db[addr_width-1] == b_base_addr[addr_width-1];
    end

    // --------------------
    // Bank write registers

    always_ff @(posedge clock) begin
        // Bank local address is the offset below the range bit
        bank_write_a.address <= split_command.da[bank_addr_width-1:0];
        bank_write_b.address <= split_command.db[bank_addr_width-1:0];

        // Both banks see the same word, a split write stores it twice
        bank_write_a.data <= split_command.data;
        bank_write_b.data <= split_command.data;

        if (reset) begin
            bank_write_a.enable <= 1'b0;
            bank_write_b.enable <= 1'b0;
        end else begin
            bank_write_a.enable <= split_command.valid && hit_a;
            bank_write_b.enable <= split_command.valid && hit_b;
        end
    end

endmodule

// ==== address_splitter.sv ====
`timescale 1ns/1ns

module address_splitter (
    input  logic clock,
    input  logic reset,
    input  write_path_pkg::write_command_t write_command,
    output write_path_pkg::split_command_t split_command
);

    import write_path_pkg::*;

    // --------------------
    // Base address upper bits

    // A split address keeps only one half of D, and the upper half of the
    // full address is filled in from the base of the target memory
    localparam logic [split_width-1:0] a_upper = a_base_addr[addr_width-1 -: split_width];
    localparam logic [split_width-1:0] b_upper = b_base_addr[addr_width-1 -: split_width];

    logic [addr_width-1:0] da_next;
    logic [addr_width-1:0] db_next;

    // --------------------
    // Split decode

    // Unsplit commands address the whole space, so both outputs carry D
    // untouched and the decoder later picks exactly one bank
    // Split commands send the upper half of D to the start of A and the
    // lower half to the start of B
    always_comb begin
        if (write_command.split) begin
            da_next = {a_upper, write_command.address.halves.upper};
            db_next = {b_upper, write_command.address.halves.lower};
        end else begin
            da_next = write_command.address.full;
            db_next = write_command.address.full;
        end
    end

    // --------------------
    // Stage register

    always_ff @(posedge clock) begin
        split_command.da <= da_next;
        split_command.db <= db_next;
        split_command.data <= write_command.data;
        // Valid qualifies the addresses and data in the next stage
        if (reset) begin
            split_command.valid <= 1'b0;
        end else begin
            split_command.valid <= write_command.valid;
        end
    end

endmodule

// ==== write_path_pkg.sv ====
package write_path_pkg;

    // --------------------
    // Widths and address map

    // Full write address space, shared by both data memories
    // The width must stay even so that D splits into two equal halves
    localparam int addr_width = 10;
    localparam int split_width = addr_width / 2;

    // One bank holds 512 words
    localparam int bank_addr_width = 9;
    localparam int data_width = 16;

    // A sits at the bottom of the space and B right above it
    localparam logic [addr_width-1:0] a_base_addr = 10'd0;
    localparam logic [addr_width-1:0] b_base_addr = 10'd512;

    // --------------------
    // Types

    // The D operand seen either as one address or as two half addresses
    // Both views cover the same bits, upper half in the high bits
    typedef union packed {
        logic [addr_width-1:0] full;
        struct packed {
            logic [split_width-1:0] upper;
            logic [split_width-1:0] lower;
        } halves;
    } d_address_t;

    // Write command as it arrives at the top level
    typedef struct packed {
        logic valid;
        logic split;
        d_address_t address;
        logic [data_width-1:0] data;
    } write_command_t;

    // Command after splitting, carrying both destination addresses
    typedef struct packed {
        logic valid;
        logic [addr_width-1:0] da;
        logic [addr_width-1:0] db;
        logic [data_width-1:0] data;
    } split_command_t;

    // Write port command for a single bank
    typedef struct packed {
        logic enable;
        logic [bank_addr_width-1:0] address;
        logic [data_width-1:0] data;
    } bank_write_t;

endpackage
